// ==== rtl/wum_macros.svh ====
`ifndef WUM_MACROS_SVH
`define WUM_MACROS_SVH

// ------------------------------------------------------------------------
// matcher sizing
// ------------------------------------------------------------------------

// number of keys held in the register block
`define WUM_NOS_KEY 2

// bytes per key, also the scan window length
`define WUM_KEY_LEN 4

// text bytes buffered between APB and the scanner
`define WUM_FIFO_DEPTH 16

// width of the controller compare counter
`define WUM_SFT_DEL_WDH 4

`endif

// ==== rtl/wum_pkg.sv ====
`include "wum_macros.svh"

package wum_pkg;

	// Wu-Manber controller states
	typedef enum logic [2:0] {
		Idle         = 3'h0,
		DataInload   = 3'h1,
		DatadeMux    = 3'h2,
		Shift        = 3'h3,
		Shift_Dat_ld = 3'h4,
		Compare      = 3'h5
	} wum_state_e;

	// skip distance to the next possible key end
	typedef struct packed {
		logic       is_hit;
		logic [6:0] skip;
	} shift_view_t;

	// one mask bit per key whose last byte matches
	typedef struct packed {
		logic                      is_hit;
		logic [6-`WUM_NOS_KEY:0]   rsvd;
		logic [`WUM_NOS_KEY-1:0]   mask;
	} hit_view_t;

	typedef union packed {
		shift_view_t sft;
		hit_view_t   hit;
	} shift_entry_u;

endpackage

// ==== rtl/apb_pkg.sv ====
package apb_pkg;

	// ------------------------------------------------------------------------
	// register map, byte addresses
	// ------------------------------------------------------------------------
	typedef enum logic [7:0] {
		CTRL   = 8'h00,
		KEY0   = 8'h04,
		KEY1   = 8'h08,
		TEXT   = 8'h0C,
		STATUS = 8'h10,
		MATCH0 = 8'h14,
		MATCH1 = 8'h18
	} apb_reg_e;

	// CTRL bits
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT  = 1;

	// STATUS fields, level is five bits wide
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_LEVEL_LSB = 4;

endpackage

// ==== rtl/wum_apb_regs.sv ====
`timescale 1ns/1ps

module wum_apb_regs (
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic        fifo_full,
	input  logic [4:0]  fifo_level,
	input  logic        scan_busy,
	input  logic [15:0] count0,
	input  logic [15:0] count1,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        push,
	output logic [7:0]  push_data,
	output logic        enable,
	output logic        clear,
	output logic [31:0] key0,
	output logic [31:0] key1
);

	logic        access;
	logic        text_stall;
	logic        mapped;
	logic        ro_reg;
	logic        wr_en;
	logic        busy;
	logic [31:0] rd_mux;

	// ------------------------------------------------------------------------
	// access decode
	// ------------------------------------------------------------------------
	assign access = psel && penable;

	// TEXT writes wait for room in the FIFO
	assign text_stall = pwrite && (paddr == apb_pkg::TEXT) && fifo_full;
	assign pready = access && !text_stall;

	always_comb begin
		mapped = 1'b0;
		ro_reg = 1'b0;
		case (paddr)
			apb_pkg::CTRL, apb_pkg::KEY0, apb_pkg::KEY1, apb_pkg::TEXT: begin
				mapped = 1'b1;
			end
			apb_pkg::STATUS, apb_pkg::MATCH0, apb_pkg::MATCH1: begin
				mapped = 1'b1;
				ro_reg = 1'b1;
			end
			default: begin
				mapped = 1'b0;
			end
		endcase
	end

	assign pslverr = pready && (!mapped || (pwrite && ro_reg));
	assign wr_en = pready && pwrite && !pslverr;

	assign push = wr_en && (paddr == apb_pkg::TEXT);
	assign push_data = pwdata[7:0];

	// ------------------------------------------------------------------------
	// control and key registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 1'b0;
			clear <= 1'b0;
			key0 <= '0;
			key1 <= '0;
		end else begin
			// clear lasts one cycle
			clear <= wr_en && (paddr == apb_pkg::CTRL) && pwdata[apb_pkg::CTRL_CLEAR_BIT];
			if (wr_en && (paddr == apb_pkg::CTRL)) begin
				enable <= pwdata[apb_pkg::CTRL_ENABLE_BIT];
			end
			if (wr_en && (paddr == apb_pkg::KEY0)) begin
				key0 <= pwdata;
			end
			if (wr_en && (paddr == apb_pkg::KEY1)) begin
				key1 <= pwdata;
			end
		end
	end

	// ------------------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------------------
	assign busy = scan_busy || (fifo_level != 5'd0);

	always_comb begin
		rd_mux = '0;
		case (paddr)
			apb_pkg::CTRL: begin
				rd_mux[apb_pkg::CTRL_ENABLE_BIT] = enable;
			end
			apb_pkg::KEY0: begin
				rd_mux = key0;
			end
			apb_pkg::KEY1: begin
				rd_mux = key1;
			end
			apb_pkg::STATUS: begin
				rd_mux[apb_pkg::STAT_BUSY_BIT] = busy;
				rd_mux[apb_pkg::STAT_LEVEL_LSB +: 5] = fifo_level;
			end
			apb_pkg::MATCH0: begin
				rd_mux[15:0] = count0;
			end
			apb_pkg::MATCH1: begin
				rd_mux[15:0] = count1;
			end
			default: begin
				rd_mux = '0;
			end
		endcase
	end

	assign prdata = (psel && !pwrite) ? rd_mux : '0;

endmodule

// ==== rtl/wum_text_fifo.sv ====
`timescale 1ns/1ps
`include "wum_macros.svh"

module wum_text_fifo (
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  logic [7:0] push_data,
	input  logic       pop,
	output logic [7:0] head,
	output logic       empty,
	output logic       full,
	output logic [4:0] level
);

	localparam int AW = $clog2(`WUM_FIFO_DEPTH);

	logic [7:0]    mem [`WUM_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(`WUM_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(`WUM_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop keeps the level
			case ({do_push, do_pop})
				2'b10: level <= level + 5'd1;
				2'b01: level <= level - 5'd1;
				default: level <= level;
			endcase
		end
	end

	// first word falls through
	assign head = mem[rd_ptr];
	assign empty = (level == 5'd0);
	assign full = (level == 5'(`WUM_FIFO_DEPTH));

endmodule

// ==== rtl/wum_fsm.sv ====
`timescale 1ns/1ps
`include "wum_macros.svh"

module wum_fsm (
	input  logic                clk,
	input  logic                reset,
	input  logic                enable,
	input  logic                dat_in_ready,
	input  logic                is_hit,
	input  logic                skip_zero,
	output logic                pop,
	output logic                window_ld,
	output logic                a_ld,
	output logic                shift_amt_ld,
	output logic                shift_amt_clr,
	output logic                compare_enable,
	output logic                compare_mux,
	output wum_pkg::wum_state_e state
);

	localparam logic [`WUM_SFT_DEL_WDH-1:0] CMP_LAST = `WUM_SFT_DEL_WDH'(`WUM_NOS_KEY - 1);

	wum_pkg::wum_state_e         next_state;
	wum_pkg::wum_state_e         next_byte;
	logic [`WUM_SFT_DEL_WDH-1:0] shift_delay;
	logic                        cmp_pend;
	logic                        cmp_last;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= wum_pkg::Idle;
		end else begin
			state <= next_state;
		end
	end

	// ------------------------------------------------------------------------
	// compare sequencing, one key per cycle
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			shift_delay <= '0;
			cmp_pend <= 1'b0;
		end else begin
			if (state == wum_pkg::Compare && !cmp_last) begin
				shift_delay <= shift_delay + 1'b1;
			end else begin
				shift_delay <= '0;
			end
			// decision taken before the skip counter moves
			if (state == wum_pkg::Shift) begin
				cmp_pend <= skip_zero && is_hit;
			end
		end
	end

	assign cmp_last = (shift_delay == CMP_LAST);

	// ------------------------------------------------------------------------
	// control pulses
	// ------------------------------------------------------------------------
	assign pop = (state == wum_pkg::DataInload);
	assign window_ld = (state == wum_pkg::DatadeMux);
	assign shift_amt_clr = (state == wum_pkg::Shift) && skip_zero && is_hit;
	assign shift_amt_ld = (state == wum_pkg::Shift) && !(skip_zero && is_hit);
	assign a_ld = (state == wum_pkg::Shift_Dat_ld);
	assign compare_enable = (state == wum_pkg::Compare);
	assign compare_mux = compare_enable && shift_delay[0];

	// straight into the next byte when one is waiting
	assign next_byte = (enable && dat_in_ready) ? wum_pkg::DataInload : wum_pkg::Idle;

	always_comb begin
		case (state)
			wum_pkg::Idle:         next_state = next_byte;
			wum_pkg::DataInload:   next_state = wum_pkg::DatadeMux;
			wum_pkg::DatadeMux:    next_state = wum_pkg::Shift;
			wum_pkg::Shift:        next_state = wum_pkg::Shift_Dat_ld;
			wum_pkg::Shift_Dat_ld: next_state = cmp_pend ? wum_pkg::Compare : next_byte;
			wum_pkg::Compare:      next_state = cmp_last ? next_byte : wum_pkg::Compare;
			default:               next_state = wum_pkg::Idle;
		endcase
	end

endmodule

// ==== rtl/wum_scan_unit.sv ====
`timescale 1ns/1ps
`include "wum_macros.svh"

module wum_scan_unit (
	input  logic        clk,
	input  logic        reset,
	input  logic        clear,
	input  logic [7:0]  head,
	input  logic [31:0] key0,
	input  logic [31:0] key1,
	input  logic        window_ld,
	input  logic        a_ld,
	input  logic        shift_amt_ld,
	input  logic        shift_amt_clr,
	input  logic        compare_enable,
	input  logic        compare_mux,
	output logic        is_hit,
	output logic        skip_zero,
	output logic [15:0] count0,
	output logic [15:0] count1
);

	localparam int WIN_W = `WUM_KEY_LEN * 8;
	localparam int SKIP_W = $clog2(`WUM_KEY_LEN);
	localparam int FILL_W = SKIP_W + 1;

	logic [WIN_W-1:0]        keys [`WUM_NOS_KEY];
	logic [7:0]              byte_q;
	logic [WIN_W-1:0]        window;
	logic [FILL_W-1:0]       fill_cnt;
	logic                    window_full;
	logic [7:0]              last_byte;
	logic [6:0]              skip_min;
	logic [`WUM_NOS_KEY-1:0] hit_mask;
	logic [`WUM_NOS_KEY-1:0] hit_mask_q;
	wum_pkg::shift_entry_u   entry;
	logic [SKIP_W-1:0]       skip_cnt;
	logic                    cmp_match;

	assign keys[0] = key0;
	assign keys[1] = key1;

	// ------------------------------------------------------------------------
	// window, newest byte on top
	// ------------------------------------------------------------------------
	// head sampled during the pop cycle
	always_ff @(posedge clk) begin
		byte_q <= head;
		if (window_ld) begin
			window <= {byte_q, window[WIN_W-1:8]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			fill_cnt <= '0;
		end else if (window_ld && !window_full) begin
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	assign window_full = (fill_cnt == FILL_W'(`WUM_KEY_LEN));
	assign last_byte = window[WIN_W-1 -: 8];

	// ------------------------------------------------------------------------
	// shift entry for the last byte
	// ------------------------------------------------------------------------
	always_comb begin
		skip_min = 7'(`WUM_KEY_LEN);
		hit_mask = '0;
		for (int k = 0; k < `WUM_NOS_KEY; k++) begin
			if (keys[k][WIN_W-1 -: 8] == last_byte) begin
				hit_mask[k] = 1'b1;
			end
			for (int i = 0; i < `WUM_KEY_LEN - 1; i++) begin
				if (keys[k][i*8 +: 8] == last_byte && 7'(`WUM_KEY_LEN - 1 - i) < skip_min) begin
					skip_min = 7'(`WUM_KEY_LEN - 1 - i);
				end
			end
		end
	end

	always_comb begin
		if (|hit_mask) begin
			entry.hit.is_hit = 1'b1;
			entry.hit.rsvd = '0;
			entry.hit.mask = hit_mask;
		end else begin
			entry.sft.is_hit = 1'b0;
			entry.sft.skip = skip_min;
		end
	end

	assign is_hit = entry.sft.is_hit;

	// bytes still to pass before the next evaluation
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			skip_cnt <= '0;
		end else if (shift_amt_clr) begin
			skip_cnt <= '0;
		end else if (shift_amt_ld) begin
			if (skip_zero) begin
				skip_cnt <= SKIP_W'(entry.sft.skip - 7'd1);
			end else begin
				skip_cnt <= skip_cnt - 1'b1;
			end
		end
	end

	assign skip_zero = (skip_cnt == '0);

	always_ff @(posedge clk) begin
		if (a_ld) begin
			hit_mask_q <= entry.sft.is_hit ? entry.hit.mask : '0;
		end
	end

	// ------------------------------------------------------------------------
	// serial key compare and counts
	// ------------------------------------------------------------------------
	assign cmp_match = window_full && hit_mask_q[compare_mux] && (window == keys[compare_mux]);

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			count0 <= '0;
			count1 <= '0;
		end else if (compare_enable && cmp_match) begin
			if (compare_mux) begin
				count1 <= count1 + 16'd1;
			end else begin
				count0 <= count0 + 16'd1;
			end
		end
	end

endmodule

// ==== rtl/wum_matcher.sv ====
`timescale 1ns/1ps

module wum_matcher (
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic                push;
	logic [7:0]          push_data;
	logic [7:0]          head;
	logic                empty;
	logic                full;
	logic [4:0]          level;
	logic                enable;
	logic                clear;
	logic [31:0]         key0;
	logic [31:0]         key1;
	logic [15:0]         count0;
	logic [15:0]         count1;
	logic                pop;
	logic                window_ld;
	logic                a_ld;
	logic                shift_amt_ld;
	logic                shift_amt_clr;
	logic                compare_enable;
	logic                compare_mux;
	logic                is_hit;
	logic                skip_zero;
	logic                scan_busy;
	wum_pkg::wum_state_e state;

	assign scan_busy = (state != wum_pkg::Idle);

	// producer
	wum_apb_regs u_wum_apb_regs (
		.clk        (clk),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.fifo_full  (full),
		.fifo_level (level),
		.scan_busy  (scan_busy),
		.count0     (count0),
		.count1     (count1),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.push       (push),
		.push_data  (push_data),
		.enable     (enable),
		.clear      (clear),
		.key0       (key0),
		.key1       (key1)
	);

	// buffer
	wum_text_fifo u_wum_text_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.head      (head),
		.empty     (empty),
		.full      (full),
		.level     (level)
	);

	// consumer
	wum_fsm u_wum_fsm (
		.clk            (clk),
		.reset          (reset),
		.enable         (enable),
		.dat_in_ready   (!empty),
		.is_hit         (is_hit),
		.skip_zero      (skip_zero),
		.pop            (pop),
		.window_ld      (window_ld),
		.a_ld           (a_ld),
		.shift_amt_ld   (shift_amt_ld),
		.shift_amt_clr  (shift_amt_clr),
		.compare_enable (compare_enable),
		.compare_mux    (compare_mux),
		.state          (state)
	);

	wum_scan_unit u_wum_scan_unit (
		.clk            (clk),
		.reset          (reset),
		.clear          (clear),
		.head           (head),
		.key0           (key0),
		.key1           (key1),
		.window_ld      (window_ld),
		.a_ld           (a_ld),
		.shift_amt_ld   (shift_amt_ld),
		.shift_amt_clr  (shift_amt_clr),
		.compare_enable (compare_enable),
		.compare_mux    (compare_mux),
		.is_hit         (is_hit),
		.skip_zero      (skip_zero),
		.count0         (count0),
		.count1         (count1)
	);

endmodule

// ==== test/wum_matcher_props.sv ====
`timescale 1ns/1ps
`include "wum_macros.svh"

module wum_matcher_props (
	input logic                clk,
	input logic                reset,
	input logic                pready,
	input logic                pslverr,
	input logic                push,
	input logic                full,
	input logic                pop,
	input logic                window_ld,
	input logic                a_ld,
	input logic                shift_amt_ld,
	input logic                shift_amt_clr,
	input logic                compare_enable,
	input logic                compare_mux,
	input wum_pkg::wum_state_e state
);

	logic       in_cmp;
	logic [5:0] pulses;

	assign in_cmp = (state == wum_pkg::Compare);
	// compare_mux rides along with compare_enable
	assign pulses = {pop, window_ld, a_ld, shift_amt_ld, shift_amt_clr, compare_enable};

	a_slverr_ready: assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
		else $error("pslverr raised without pready");

	a_push_room: assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("FIFO push while full");

	a_cmp_held: assert property (@(posedge clk) disable iff (reset)
		$rose(in_cmp) |-> ##(`WUM_NOS_KEY - 1) in_cmp)
		else $error("Compare left early");

	a_cmp_left: assert property (@(posedge clk) disable iff (reset)
		$rose(in_cmp) |-> ##(`WUM_NOS_KEY) !in_cmp)
		else $error("Compare held too long");

	a_one_pulse: assert property (@(posedge clk) disable iff (reset)
		$onehot0(pulses) && (!compare_mux || compare_enable))
		else $error("more than one controller pulse active");

endmodule

bind wum_matcher wum_matcher_props u_wum_matcher_props (
	.clk            (clk),
	.reset          (reset),
	.pready         (pready),
	.pslverr        (pslverr),
	.push           (push),
	.full           (full),
	.pop            (pop),
	.window_ld      (window_ld),
	.a_ld           (a_ld),
	.shift_amt_ld   (shift_amt_ld),
	.shift_amt_clr  (shift_amt_clr),
	.compare_enable (compare_enable),
	.compare_mux    (compare_mux),
	.state          (state)
);

// ==== test/wum_matcher_tb.sv ====
`timescale 1ns/1ps
`include "wum_macros.svh"

module wum_matcher_tb;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// case table, one entry per column
	string       tbl_key0 [$];
	string       tbl_key1 [$];
	string       tbl_text [$];
	int          tbl_rand_len [$];
	int          tbl_alpha [$];
	bit          tbl_preload [$];
	bit          tbl_probe [$];
	bit          table_ready;
	int          errors;

	wum_matcher u_wum_matcher (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
	endtask

	task automatic add_case(input string k0, input string k1, input string txt,
			input int rand_len, input int alpha, input bit preload, input bit probe);
		tbl_key0.push_back(k0);
		tbl_key1.push_back(k1);
		tbl_text.push_back(txt);
		tbl_rand_len.push_back(rand_len);
		tbl_alpha.push_back(alpha);
		tbl_preload.push_back(preload);
		tbl_probe.push_back(probe);
	endtask

	// key0, key1, text, random length, alphabet size, preload, error probe
	task automatic build_table();
		add_case("abcd", "wxyz", "xxabcdxx", 0, 0, 1'b0, 1'b0);
		add_case("abab", "baba", "ababab", 0, 0, 1'b0, 1'b0);
		add_case("abcd", "cdab", "abcdabcdab", 0, 0, 1'b0, 1'b0);
		add_case("abcd", "efgh", "qrstuvqrstuvwq", 0, 0, 1'b0, 1'b0);
		add_case("abcd", "efgh", "aaabbbcccaaebbc", 0, 0, 1'b0, 1'b0);
		add_case("abba", "baab", "abbaabbabaabbaababbaabbaab", 0, 0, 1'b1, 1'b0);
		add_case("abcd", "bcda", "abcdabcd", 0, 0, 1'b0, 1'b1);
		add_case("", "", "", 40, 2, 1'b0, 1'b0);
		add_case("", "", "", 48, 2, 1'b0, 1'b0);
		add_case("", "", "", 48, 3, 1'b0, 1'b0);
		add_case("", "", "", 64, 2, 1'b0, 1'b0);
	endtask

	// byte 0 of a key is its first character
	function automatic logic [31:0] str_to_key(input string s);
		logic [31:0] key;
		key = '0;
		for (int i = 0; i < 4; i++) begin
			key[i*8 +: 8] = s[i];
		end
		return key;
	endfunction

	function automatic logic [7:0] rand_letter(input int alpha);
		return 8'(8'h61 + $urandom_range(alpha - 1, 0));
	endfunction

	// every window position counts, overlaps included
	function automatic int ref_count(input logic [7:0] txt [$], input logic [31:0] key);
		int n;
		n = 0;
		for (int i = 0; i + 3 < txt.size(); i++) begin
			if ({txt[i+3], txt[i+2], txt[i+1], txt[i]} == key) begin
				n++;
			end
		end
		return n;
	endfunction

	// ------------------------------------------------------------------------
	// APB master
	// ------------------------------------------------------------------------
	task automatic apb_access(input bit wr, input logic [7:0] addr, input logic [31:0] data,
			input int max_wait, output logic [31:0] rdata, output logic slverr, output bit done);
		int waits;
		done = 1'b0;
		waits = 0;
		rdata = '0;
		slverr = 1'b0;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		while (!done && waits < max_wait) begin
			@(negedge clk);
			if (pready) begin
				done = 1'b1;
				rdata = prdata;
				slverr = pslverr;
			end else begin
				waits++;
			end
		end
		// an access that never completed is dropped here
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] unused;
		logic        slverr;
		bit          done;
		apb_access(1'b1, addr, data, 64, unused, slverr, done);
		if (!done) begin
			errors++;
			$display("** Error at %0d ns: write to 0x%0h never completed", $time, addr);
		end
		if (done && slverr !== exp_err) begin
			report_mismatch("pslverr", 32'(slverr), 32'(exp_err));
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
		logic slverr;
		bit   done;
		apb_access(1'b0, addr, 32'h0, 64, data, slverr, done);
		if (!done) begin
			errors++;
			$display("** Error at %0d ns: read from 0x%0h never completed", $time, addr);
		end
		if (done && slverr !== exp_err) begin
			report_mismatch("pslverr", 32'(slverr), 32'(exp_err));
		end
	endtask

	task automatic wait_idle(input int max_polls);
		logic [31:0] st;
		int          polls;
		polls = 0;
		st = 32'h1;
		while (st[apb_pkg::STAT_BUSY_BIT] && polls < max_polls) begin
			apb_read(apb_pkg::STATUS, st, 1'b0);
			polls++;
		end
		if (st[apb_pkg::STAT_BUSY_BIT]) begin
			errors++;
			$display("** Error at %0d ns: STATUS busy still set after %0d polls", $time, polls);
		end
	endtask

	// ------------------------------------------------------------------------
	// one table entry
	// ------------------------------------------------------------------------
	task automatic run_case(input int c);
		logic [7:0]  txt [$];
		logic [31:0] k0;
		logic [31:0] k1;
		logic [31:0] rd;
		logic [31:0] exp_status;
		logic        slverr;
		bit          done;
		int          exp0;
		int          exp1;
		int          first;
		string       s;
		if (tbl_rand_len[c] > 0) begin
			for (int i = 0; i < 4; i++) begin
				k0[i*8 +: 8] = rand_letter(tbl_alpha[c]);
				k1[i*8 +: 8] = rand_letter(tbl_alpha[c]);
			end
			for (int i = 0; i < tbl_rand_len[c]; i++) begin
				txt.push_back(rand_letter(tbl_alpha[c]));
			end
		end else begin
			k0 = str_to_key(tbl_key0[c]);
			k1 = str_to_key(tbl_key1[c]);
			s = tbl_text[c];
			for (int i = 0; i < s.len(); i++) begin
				txt.push_back(s[i]);
			end
		end
		exp0 = ref_count(txt, k0);
		exp1 = ref_count(txt, k1);
		apb_write(apb_pkg::KEY0, k0, 1'b0);
		apb_write(apb_pkg::KEY1, k1, 1'b0);
		first = 0;
		if (tbl_preload[c]) begin
			// scanner held off, FIFO fills up
			apb_write(apb_pkg::CTRL, 32'h0, 1'b0);
			for (first = 0; first < `WUM_FIFO_DEPTH; first++) begin
				apb_write(apb_pkg::TEXT, {24'h0, txt[first]}, 1'b0);
			end
			exp_status = '0;
			exp_status[apb_pkg::STAT_LEVEL_LSB +: 5] = 5'(`WUM_FIFO_DEPTH);
			exp_status[apb_pkg::STAT_BUSY_BIT] = 1'b1;
			apb_read(apb_pkg::STATUS, rd, 1'b0);
			if (rd !== exp_status) begin
				report_mismatch("STATUS", rd, exp_status);
			end
			apb_access(1'b1, apb_pkg::TEXT, {24'h0, txt[first]}, 8, rd, slverr, done);
			if (done) begin
				errors++;
				$display("** Error at %0d ns: TEXT write completed into a full FIFO", $time);
			end
			apb_write(apb_pkg::CTRL, 32'h1, 1'b0);
		end
		for (int i = first; i < txt.size(); i++) begin
			apb_write(apb_pkg::TEXT, {24'h0, txt[i]}, 1'b0);
		end
		wait_idle(txt.size() * 6 + 20);
		apb_read(apb_pkg::MATCH0, rd, 1'b0);
		if (rd !== 32'(exp0)) begin
			report_mismatch("MATCH0", rd, 32'(exp0));
		end
		apb_read(apb_pkg::MATCH1, rd, 1'b0);
		if (rd !== 32'(exp1)) begin
			report_mismatch("MATCH1", rd, 32'(exp1));
		end
		if (tbl_probe[c]) begin
			apb_read(8'h1C, rd, 1'b1);
			apb_write(8'h40, 32'h1, 1'b1);
			apb_write(apb_pkg::MATCH0, 32'hFFFF, 1'b1);
			apb_write(apb_pkg::MATCH1, 32'h0, 1'b1);
			apb_write(apb_pkg::STATUS, 32'h0, 1'b1);
			apb_read(apb_pkg::MATCH0, rd, 1'b0);
			if (rd !== 32'(exp0)) begin
				report_mismatch("MATCH0", rd, 32'(exp0));
			end
			apb_read(apb_pkg::MATCH1, rd, 1'b0);
			if (rd !== 32'(exp1)) begin
				report_mismatch("MATCH1", rd, 32'(exp1));
			end
		end
		// counts and window cleared, enable kept
		apb_write(apb_pkg::CTRL, 32'h3, 1'b0);
	endtask

	initial begin : main
		logic [31:0] rd;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h0;
		pwdata = 32'h0;
		errors = 0;
		void'($urandom(32'h8e11cbe9));
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		apb_read(apb_pkg::STATUS, rd, 1'b0);
		if (rd !== 32'h0) begin
			report_mismatch("STATUS", rd, 32'h0);
		end
		apb_read(apb_pkg::MATCH0, rd, 1'b0);
		if (rd !== 32'h0) begin
			report_mismatch("MATCH0", rd, 32'h0);
		end
		apb_read(apb_pkg::MATCH1, rd, 1'b0);
		if (rd !== 32'h0) begin
			report_mismatch("MATCH1", rd, 32'h0);
		end
		apb_write(apb_pkg::KEY0, 32'h5a3c96e1, 1'b0);
		apb_read(apb_pkg::KEY0, rd, 1'b0);
		if (rd !== 32'h5a3c96e1) begin
			report_mismatch("KEY0", rd, 32'h5a3c96e1);
		end
		apb_write(apb_pkg::KEY1, 32'hc3a50f78, 1'b0);
		apb_read(apb_pkg::KEY1, rd, 1'b0);
		if (rd !== 32'hc3a50f78) begin
			report_mismatch("KEY1", rd, 32'hc3a50f78);
		end

		apb_write(apb_pkg::CTRL, 32'h1, 1'b0);
		for (int c = 0; c < tbl_text.size(); c++) begin
			run_case(c);
		end

		$display("cases run: %0d, errors: %0d", tbl_text.size(), errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// worst case six cycles a byte, plus APB traffic per case
	initial begin : watchdog
		int total;
		int limit;
		wait (table_ready);
		total = 0;
		for (int c = 0; c < tbl_text.size(); c++) begin
			total += (tbl_rand_len[c] > 0) ? tbl_rand_len[c] : tbl_text[c].len();
		end
		limit = total * 6 + tbl_text.size() * 200 + 500;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/wum_pkg.sv
rtl/apb_pkg.sv
rtl/wum_apb_regs.sv
rtl/wum_text_fifo.sv
rtl/wum_fsm.sv
rtl/wum_scan_unit.sv
rtl/wum_matcher.sv
test/wum_matcher_props.sv
test/wum_matcher_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the matcher testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module wum_matcher_tb \
	-f sources.f --Mdir obj_dir -o wum_matcher_sim \
	&& ./obj_dir/wum_matcher_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && exit 0 || exit 1
